// File: tb.f
hw/fib_pkg.sv
hw/fib_generator.sv
hw/bin_to_bcd.sv
hw/seg7_scan.sv
hw/fib_display_top.sv
testbench/tb_fib_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fibonacci display testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_fib_display
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module "$TOP" \
    -f tb.f \
    -Mdir obj_dir

./obj_dir/V"$TOP" | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"

// File: testbench/tb_fib_display.sv
//*********************************************************************
// fibonacci display testbench
// runs index sweeps, overflow, busy-start and random runs against a
// reference model, checks latency, strobes and the scanned display
//*********************************************************************

module tb_fib_display;
    timeunit 1ns;
    timeprecision 100ps;

    import fib_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int SCAN_DIV     = 4;
    localparam int DONE_LIMIT   = 100;
    // sweep 0..20, overflow 21..31, flag clear, busy pokes, random runs
    localparam int N_TESTS         = 21 + 11 + 1 + 4 + 40;
    localparam int WATCHDOG_CYCLES = N_TESTS * 40 + 1000;
    localparam logic [31:0] LFSR_SEED = 32'h5809_e956;

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_start;
    logic [IDX_W-1:0]      i_index;
    logic                  o_ready;
    logic                  o_done;
    logic                  o_overflow;
    bcd_word_u             o_bcd;
    logic [6:0]            o_seg;
    logic [BCD_DIGITS-1:0] o_an;

    int          err_count = 0;
    int          tests_run = 0;
    int          done_count = 0;
    logic [31:0] lfsr_state;
    bcd_word_u   exp_bcd;
    bit          exp_ovf;

    fib_display_top #(.SCAN_DIV(SCAN_DIV)) UUT
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_index    (i_index),
        .o_ready    (o_ready),
        .o_done     (o_done),
        .o_overflow (o_overflow),
        .o_bcd      (o_bcd),
        .o_seg      (o_seg),
        .o_an       (o_an)
    );

    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // true F(n) in 32 bits, clamped to the display range at the end
    function automatic void fib_ref(input int n, output int val, output bit ovf);
        int a;
        int b;
        int t;
        a = 0;
        b = 1;
        for (int i = 0; i < n; i++)
        begin
            t = a + b;
            a = b;
            b = t;
        end
        ovf = (a > int'(BCD_MAX));
        val = ovf ? int'(BCD_MAX) : a;
    endfunction

    function automatic bcd_word_u to_digits(input int v);
        bcd_word_u r;
        int rest;
        rest = v;
        for (int i = 0; i < BCD_DIGITS; i++)
        begin
            r.digit[i] = 4'(rest % 10);
            rest = rest / 10;
        end
        return r;
    endfunction

    // active-low pattern, bit order g f e d c b a
    function automatic logic [6:0] seg_pattern(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b100_0000;
            4'd1:    return 7'b111_1001;
            4'd2:    return 7'b010_0100;
            4'd3:    return 7'b011_0000;
            4'd4:    return 7'b001_1001;
            4'd5:    return 7'b001_0010;
            4'd6:    return 7'b000_0010;
            4'd7:    return 7'b111_1000;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b001_0000;
            default: return 7'b111_1111;
        endcase
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] r;
        r = s >> 1;
        if (s[0])
        begin
            r = r ^ 32'h8020_0003;
        end
        return r;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_bcd(input bcd_word_u got, input bcd_word_u exp, input string what);
        if (got.word !== exp.word)
        begin
            $display("CHECK FAILED @ %0t: %s got %h expected %h", $time, what, got.word,
                     exp.word);
            err_count++;
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED @ %0t: %s got %b expected %b", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_seg(input logic [6:0] got_seg, input logic [6:0] exp_seg,
                             input logic [3:0] got_an, input logic [3:0] exp_an,
                             input string what);
        if (got_seg !== exp_seg || got_an !== exp_an)
        begin
            $display("CHECK FAILED @ %0t: %s got seg %b an %b expected seg %b an %b",
                     $time, what, got_seg, got_an, exp_seg, exp_an);
            err_count++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("CHECK FAILED @ %0t: %s got %0d cycles expected %0d", $time, what, got,
                     exp);
            err_count++;
        end
    endtask

    // result compare on every done pulse
    always @(negedge i_clk)
    begin
        if (o_done)
        begin
            done_count = done_count + 1;
            check_bcd(o_bcd, exp_bcd, "result digits");
            check_flag(o_overflow, exp_ovf, "overflow flag");
        end
    end

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!o_ready && waited < DONE_LIMIT)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_ready)
        begin
            $display("ready never returned after %0d cycles at %0t", waited, $time);
            err_count++;
        end
    endtask

    // one run of index n, poke raises a start while busy
    task automatic run_test(input int n, input bit poke);
        int ref_val;
        bit ref_ovf;
        int edges;
        bit seen;
        wait_ready();
        fib_ref(n, ref_val, ref_ovf);
        exp_bcd = to_digits(ref_val);
        exp_ovf = ref_ovf;
        i_start = 1'b1;
        i_index = IDX_W'(n);
        @(negedge i_clk);
        i_start = 1'b0;
        edges = 0;
        seen = 1'b0;
        while (!seen && edges < DONE_LIMIT)
        begin
            @(negedge i_clk);
            edges++;
            if (poke)
            begin
                i_start = (edges == 2);
                i_index = IDX_W'(31 - n);
            end
            if (o_done)
                seen = 1'b1;
            else
                check_flag(o_ready, 1'b0, "ready during run");
        end
        tests_run++;
        if (!seen)
        begin
            $display("no done pulse for index %0d within %0d cycles", n, DONE_LIMIT);
            err_count++;
            return;
        end
        check_latency(edges, n + 17, "done latency");
        @(negedge i_clk);
        check_flag(o_done, 1'b0, "done pulse width");
        check_flag(o_ready, 1'b1, "ready after done");
    endtask

    // lock to a digit change, then follow 16 scan steps
    task automatic check_display();
        logic [3:0] last_an;
        int waited;
        int start_k;
        int k;
        last_an = o_an;
        waited = 0;
        while (o_an == last_an && waited < 2 * SCAN_DIV)
        begin
            @(negedge i_clk);
            waited++;
        end
        start_k = -1;
        for (int i = 0; i < BCD_DIGITS; i++)
        begin
            if (o_an == 4'(~(4'b0001 << i)))
                start_k = i;
        end
        if (o_an == last_an || start_k < 0)
        begin
            $display("display scan is stuck or selects no single digit at %0t", $time);
            err_count++;
            return;
        end
        for (int s = 0; s < 16; s++)
        begin
            k = (start_k + s) % BCD_DIGITS;
            repeat (SCAN_DIV)
            begin
                check_seg(o_seg, seg_pattern(exp_bcd.digit[k]), o_an, 4'(~(4'b0001 << k)),
                          "display scan");
                @(negedge i_clk);
            end
        end
    endtask

    initial
    begin : stimulus
        int n;
        int gap;
        lfsr_state = LFSR_SEED;
        i_rst = 1'b1;
        i_start = 1'b0;
        i_index = '0;
        exp_bcd = to_digits(0);
        exp_ovf = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst = 1'b0;

        check_flag(o_ready, 1'b1, "ready after reset");
        check_flag(o_done, 1'b0, "done after reset");
        check_flag(o_overflow, 1'b0, "overflow after reset");
        check_bcd(o_bcd, to_digits(0), "result after reset");
        check_seg(o_seg, seg_pattern(4'd0), o_an, 4'b1110, "scan after reset");

        for (int i = 0; i <= 20; i++)
        begin
            run_test(i, 1'b0);
            if (i == 8 || i == 20)
                check_display();
        end
        for (int i = 21; i <= 31; i++)
            run_test(i, 1'b0);
        check_display();
        // a small index must clear the overflow flag again
        run_test(3, 1'b0);

        run_test(5, 1'b1);
        run_test(12, 1'b1);
        run_test(0, 1'b1);
        run_test(25, 1'b1);

        for (int i = 0; i < 40; i++)
        begin
            draw_bits(IDX_W, n);
            run_test(n, 1'b0);
            draw_bits(3, gap);
            repeat (gap) @(negedge i_clk);
        end

        if (done_count != N_TESTS)
        begin
            $display("saw %0d done pulses for %0d runs", done_count, N_TESTS);
            err_count++;
        end
        $display("tests: %0d, done pulses: %0d, errors: %0d", tests_run, done_count, err_count);
        if (err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests: %0d, done pulses: %0d, errors: %0d", tests_run, done_count, err_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: hw/fib_display_top.sv
//*********************************************************************
// fibonacci display top level
// generator feeds the BCD converter, whose digits go to the
// seven-segment scan
//*********************************************************************

module fib_display_top
#(
    parameter int unsigned SCAN_DIV = 4
)
(
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_start,
    input  logic [fib_pkg::IDX_W-1:0]      i_index,
    output logic                           o_ready,
    output logic                           o_done,
    output logic                           o_overflow,
    output fib_pkg::bcd_word_u             o_bcd,
    output logic [6:0]                     o_seg,
    output logic [fib_pkg::BCD_DIGITS-1:0] o_an
);
    import fib_pkg::*;

    // generator to converter
    logic             w_conv_ready;
    logic             w_conv_start;
    logic [BIN_W-1:0] w_conv_bin;

    fib_generator u_generator
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_index      (i_index),
        .i_conv_ready (w_conv_ready),
        .i_conv_done  (o_done),
        .o_ready      (o_ready),
        .o_overflow   (o_overflow),
        .o_conv_start (w_conv_start),
        .o_conv_bin   (w_conv_bin)
    );

    // converter done doubles as the top-level done strobe
    bin_to_bcd u_converter
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (w_conv_start),
        .i_bin   (w_conv_bin),
        .o_ready (w_conv_ready),
        .o_done  (o_done),
        .o_bcd   (o_bcd)
    );

    seg7_scan
    #(
        .SCAN_DIV (SCAN_DIV)
    )
    u_scan
    (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_bcd (o_bcd),
        .o_seg (o_seg),
        .o_an  (o_an)
    );

endmodule

// File: hw/seg7_scan.sv
//*********************************************************************
// seven-segment scan
// steps through the four BCD digits, decodes the selected one to
// active-low segments and pulls its anode low
//*********************************************************************

module seg7_scan
#(
    parameter int unsigned SCAN_DIV = 4
)
(
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  fib_pkg::bcd_word_u             i_bcd,
    output logic [6:0]                     o_seg,
    output logic [fib_pkg::BCD_DIGITS-1:0] o_an
);
    import fib_pkg::*;

    localparam int unsigned DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int unsigned SEL_W = $clog2(BCD_DIGITS);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

    logic [DIV_W-1:0]   r_div;
    logic [SEL_W-1:0]   r_sel;
    logic [DIGIT_W-1:0] w_digit;
    // active-high segments with a in bit 0
    logic [6:0]         w_seg_on;

    // divider and digit select
    // the select wraps after the last digit
    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_div <= '0;
            r_sel <= '0;
        end
        else if (r_div == DIV_LAST)
        begin
            r_div <= '0;
            r_sel <= r_sel + 1'b1;
        end
        else
        begin
            r_div <= r_div + 1'b1;
        end
    end

    assign w_digit = i_bcd.digit[r_sel];

    always_comb
    begin : seg_decode
        case (w_digit)
            4'd0:    w_seg_on = 7'b011_1111;
            4'd1:    w_seg_on = 7'b000_0110;
            4'd2:    w_seg_on = 7'b101_1011;
            4'd3:    w_seg_on = 7'b100_1111;
            4'd4:    w_seg_on = 7'b110_0110;
            4'd5:    w_seg_on = 7'b110_1101;
            4'd6:    w_seg_on = 7'b111_1101;
            4'd7:    w_seg_on = 7'b000_0111;
            4'd8:    w_seg_on = 7'b111_1111;
            4'd9:    w_seg_on = 7'b110_1111;
            // codes 10 to 15 stay dark
            default: w_seg_on = 7'b000_0000;
        endcase
    end

    assign o_seg = ~w_seg_on;
    assign o_an  = ~(BCD_DIGITS'(1) << r_sel);

    // the lit digit moves on by one place, wrapping, each time the divider ends
    a_scan_step: assert property (@(posedge i_clk) disable iff (i_rst)
        (r_div == DIV_LAST) |=>
            (o_an == {$past(o_an[BCD_DIGITS-2:0]), $past(o_an[BCD_DIGITS-1])}));

endmodule

// File: hw/bin_to_bcd.sv
//*********************************************************************
// binary to BCD converter
// turns a 14-bit value of at most 9999 into four BCD digits with the
// shift-and-add-3 method, one bit per cycle
//*********************************************************************

module bin_to_bcd
(
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_start,
    input  logic [fib_pkg::BIN_W-1:0] i_bin,
    output logic                      o_ready,
    output logic                      o_done,
    output fib_pkg::bcd_word_u        o_bcd
);
    import fib_pkg::*;

    localparam int unsigned CNT_W = $clog2(BIN_W + 1);
    localparam logic [BIN_W-1:0] LIMIT = BIN_W'(BCD_MAX);

    typedef enum logic [1:0] {e_ready, e_operation, e_done} t_state;

    t_state           r_state;
    t_state           w_state_next;
    logic [BIN_W-1:0] r_bin;
    logic [BIN_W-1:0] w_bin_next;
    bcd_word_u        r_bcd;
    bcd_word_u        w_bcd_next;
    bcd_word_u        w_bcd_adj;
    logic [CNT_W-1:0] r_index;
    logic [CNT_W-1:0] w_index_next;

    // add 3 to every digit of 5 or more before the shift
    always_comb
    begin : bcd_adjust
        for (int d = 0; d < BCD_DIGITS; d++)
        begin
            if (r_bcd.digit[d] > 4'd4)
            begin
                w_bcd_adj.digit[d] = r_bcd.digit[d] + 4'd3;
            end
            else
            begin
                w_bcd_adj.digit[d] = r_bcd.digit[d];
            end
        end
    end

    always_ff @(posedge i_clk, posedge i_rst)
    begin : state_regs
        if (i_rst)
        begin
            r_state <= e_ready;
            r_bcd   <= '0;
            r_index <= '0;
        end
        else
        begin
            r_state <= w_state_next;
            r_bcd   <= w_bcd_next;
            r_index <= w_index_next;
        end
    end

    always_ff @(posedge i_clk)
    begin : shift_reg
        r_bin <= w_bin_next;
    end

    always_comb
    begin : next_state_logic
        w_state_next = r_state;
        w_bin_next   = r_bin;
        w_bcd_next   = r_bcd;
        w_index_next = r_index;
        o_ready      = 1'b0;
        o_done       = 1'b0;

        case (r_state)
            e_ready:
            begin
                o_ready = 1'b1;
                if (i_start)
                begin
                    w_bin_next   = i_bin;
                    w_bcd_next   = '0;
                    w_index_next = CNT_W'(BIN_W);
                    w_state_next = e_operation;
                end
            end
            e_operation:
            begin
                if (r_index == '0)
                begin
                    w_state_next = e_done;
                end
                else
                begin
                    // digit chain and binary word move left together
                    w_bcd_next.word = {w_bcd_adj.word[BCD_W-2:0], r_bin[BIN_W-1]};
                    w_bin_next      = r_bin << 1;
                    w_index_next    = r_index - 1'b1;
                end
            end
            e_done:
            begin
                o_done       = 1'b1;
                w_state_next = e_ready;
            end
            default:
            begin
                w_state_next = e_ready;
            end
        endcase
    end

    assign o_bcd = r_bcd;

    // values above 9999 would overflow the thousands digit
    a_bin_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_start && o_ready) |-> (i_bin <= LIMIT));

endmodule

// File: hw/fib_generator.sv
//*********************************************************************
// fibonacci generator
// captures a start index, iterates F(n) one addition per cycle with
// saturation at 9999, then hands the result to the BCD converter
//*********************************************************************

module fib_generator
(
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_start,
    input  logic [fib_pkg::IDX_W-1:0] i_index,
    input  logic                      i_conv_ready,
    input  logic                      i_conv_done,
    output logic                      o_ready,
    output logic                      o_overflow,
    output logic                      o_conv_start,
    output logic [fib_pkg::BIN_W-1:0] o_conv_bin
);
    import fib_pkg::*;

    localparam logic [BIN_W-1:0] LIMIT = BIN_W'(BCD_MAX);

    typedef enum logic [1:0] {e_idle, e_run, e_issue, e_wait} t_state;

    t_state           r_state;
    logic [IDX_W-1:0] r_count;
    // running terms, a holds F(k) and b holds F(k+1)
    logic [BIN_W-1:0] r_term_a;
    logic [BIN_W-1:0] r_term_b;
    // b has been clamped at some point
    logic             r_b_sat;
    logic             r_ovf;
    logic [BIN_W:0]   w_sum;
    logic             w_sum_sat;
    logic [BIN_W-1:0] w_sum_clamped;
    logic             w_accept;

    assign w_accept      = i_start && o_ready;
    assign w_sum         = {1'b0, r_term_a} + {1'b0, r_term_b};
    assign w_sum_sat     = w_sum > {1'b0, LIMIT};
    assign w_sum_clamped = w_sum_sat ? LIMIT : w_sum[BIN_W-1:0];

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_count <= '0;
            r_b_sat <= 1'b0;
            r_ovf   <= 1'b0;
        end
        else
        begin
            case (r_state)
                e_idle:
                begin
                    if (w_accept)
                    begin
                        r_count <= i_index;
                        r_b_sat <= 1'b0;
                        r_ovf   <= 1'b0;
                        r_state <= e_run;
                    end
                end
                e_run:
                begin
                    // always n additions, saturation does not cut the count short
                    if (r_count == '0)
                    begin
                        r_state <= e_issue;
                    end
                    else
                    begin
                        r_count <= r_count - 1'b1;
                        // a takes over b, so a clamped b becomes the result flag
                        r_ovf   <= r_ovf | r_b_sat;
                        r_b_sat <= r_b_sat | w_sum_sat;
                    end
                end
                e_issue:
                begin
                    r_state <= e_wait;
                end
                e_wait:
                begin
                    if (i_conv_done)
                    begin
                        r_state <= e_idle;
                    end
                end
                default:
                begin
                    r_state <= e_idle;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (r_state == e_idle && w_accept)
        begin
            r_term_a <= '0;
            r_term_b <= BIN_W'(1);
        end
        else if (r_state == e_run && r_count != '0)
        begin
            r_term_a <= r_term_b;
            r_term_b <= w_sum_clamped;
        end
    end

    assign o_ready      = (r_state == e_idle) && i_conv_ready;
    assign o_conv_start = (r_state == e_issue);
    assign o_conv_bin   = r_term_a;
    assign o_overflow   = r_ovf;

    // the converter must be idle whenever a conversion is issued
    a_start_needs_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        o_conv_start |-> i_conv_ready);

endmodule

// File: hw/fib_pkg.sv
//*********************************************************************
// fibonacci display package
// shared widths, the saturation limit and the BCD result word that is
// read either as one raw word or as four decimal digits
//*********************************************************************

package fib_pkg;

    // binary result width, enough for the saturated value 9999
    localparam int unsigned BIN_W = 14;

    // index width, n runs from 0 to 31
    localparam int unsigned IDX_W = 5;

    // number of decimal digits on the display
    localparam int unsigned BCD_DIGITS = 4;

    // width of one BCD digit
    localparam int unsigned DIGIT_W = 4;

    // width of the whole BCD word
    localparam int unsigned BCD_W = BCD_DIGITS * DIGIT_W;

    // largest value that fits the four digits
    // the generator clamps its result here
    localparam int unsigned BCD_MAX = 9999;

    // BCD result word
    // word view is the raw 16 bits, digit view gives the nibbles
    // digit[0] is the ones digit, digit[3] the thousands
    typedef union packed
    {
        logic [BCD_W-1:0]                    word;
        logic [BCD_DIGITS-1:0][DIGIT_W-1:0] digit;
    } bcd_word_u;

endpackage
